// ==== hw/mul_settings.svh ====
`ifndef MUL_SETTINGS_SVH
`define MUL_SETTINGS_SVH

// operand and result width in bits
`define MUL_XLEN 32

// number of multiply lanes behind the bus, 2, 4 or 8
`define MUL_LANES 4

// 1 selects the single-cycle lane, 0 the shift-add lane
`define MUL_FAST 0

`endif

// ==== hw/mul_types_pkg.sv ====
`include "mul_settings.svh"

package mul_types_pkg;

  typedef logic [`MUL_XLEN-1:0] word_t;
  typedef logic [2*`MUL_XLEN-1:0] dword_t;

  // encodings follow the low bits of the M-extension funct3 for multiplies
  typedef enum logic [1:0] {
    MUL_LO  = 2'd0,  // low word, signed x signed
    MUL_H   = 2'd1,  // high word, signed x signed
    MUL_HSU = 2'd2,  // high word, signed a x unsigned b
    MUL_HU  = 2'd3   // high word, unsigned x unsigned
  } mul_op_t;

  typedef enum logic [1:0] {
    IDLE,
    SHIFT,
    FINISH
  } lane_state_t;

endpackage

// ==== hw/bus_types_pkg.sv ====
`include "mul_settings.svh"

package bus_types_pkg;

  // word offsets on the slave port, result i sits at RESULT0 + i
  typedef enum logic [4:0] {
    OPA     = 5'd0,
    OPB     = 5'd1,
    CMD     = 5'd2,
    LAST    = 5'd3,
    STATUS  = 5'd4,
    RESULT0 = 5'd8
  } reg_off_t;

  typedef logic [$clog2(`MUL_LANES)-1:0] lane_idx_t;
  typedef logic [`MUL_LANES-1:0] lane_mask_t;

endpackage

// ==== hw/mul_lane.sv ====
`include "mul_settings.svh"

module mul_lane (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  input  mul_types_pkg::mul_op_t op,
  input  mul_types_pkg::word_t   rs1,
  input  mul_types_pkg::word_t   rs2,
  output logic                   busy,
  output logic                   done,
  output mul_types_pkg::word_t   result
);
  import mul_types_pkg::*;

  logic                      a_signed;
  logic                      b_signed;
  logic signed [`MUL_XLEN:0] a_ext;
  logic signed [`MUL_XLEN:0] b_ext;

  assign a_signed = (op != MUL_HU);  // only mulhu treats rs1 as unsigned
  assign b_signed = (op == MUL_LO) || (op == MUL_H);
  assign a_ext    = {a_signed & rs1[`MUL_XLEN-1], rs1};
  assign b_ext    = {b_signed & rs2[`MUL_XLEN-1], rs2};

  if (`MUL_FAST == 0) begin : g_iter
    lane_state_t                  state;
    logic [$clog2(`MUL_XLEN)-1:0] cnt;
    word_t                        mag_a;
    word_t                        mag_b;
    dword_t                       mcand;
    word_t                        mplier;
    dword_t                       acc;
    dword_t                       signed_prod;
    logic                         neg;
    mul_op_t                      op_q;

    // 0x80000000 negates to itself, which is the right unsigned magnitude
    assign mag_a       = a_ext[`MUL_XLEN] ? -rs1 : rs1;
    assign mag_b       = b_ext[`MUL_XLEN] ? -rs2 : rs2;
    assign signed_prod = neg ? -acc : acc;

    // the done cycle counts as busy so the lane is not picked again before pending rises
    assign busy = (state != IDLE) || done;

    always_ff @(posedge clk) begin
      if (!rst) begin
        state <= IDLE;
        cnt   <= '0;
        done  <= 1'b0;
      end else begin
        done <= 1'b0;
        case (state)
          IDLE: begin
            if (start) begin
              state <= SHIFT;
              cnt   <= '0;
            end
          end
          SHIFT: begin
            cnt <= cnt + 1'b1;
            if (cnt == '1) begin  // last of the XLEN steps
              state <= FINISH;
            end
          end
          FINISH: begin
            done  <= 1'b1;
            state <= IDLE;
          end
          default: state <= IDLE;
        endcase
      end
    end

    always_ff @(posedge clk) begin
      case (state)
        IDLE: begin
          if (start) begin
            acc    <= '0;
            mcand  <= {{`MUL_XLEN{1'b0}}, mag_a};
            mplier <= mag_b;
            neg    <= a_ext[`MUL_XLEN] ^ b_ext[`MUL_XLEN];
            op_q   <= op;
          end
        end
        SHIFT: begin
          if (mplier[0]) begin
            acc <= acc + mcand;
          end
          mcand  <= mcand << 1;
          mplier <= mplier >> 1;
        end
        FINISH: begin
          if (op_q == MUL_LO) begin
            result <= signed_prod[`MUL_XLEN-1:0];
          end else begin
            result <= signed_prod[2*`MUL_XLEN-1:`MUL_XLEN];
          end
        end
        default: ;
      endcase
    end
  end else begin : g_fast
    logic signed [2*`MUL_XLEN+1:0] prod;

    assign prod = a_ext * b_ext;  // 33 x 33 signed covers all four cases
    assign busy = done;

    always_ff @(posedge clk) begin
      if (!rst) begin
        done <= 1'b0;
      end else begin
        done <= start;
      end
    end

    always_ff @(posedge clk) begin
      if (start) begin
        if (op == MUL_LO) begin
          result <= prod[`MUL_XLEN-1:0];
        end else begin
          result <= prod[2*`MUL_XLEN-1:`MUL_XLEN];
        end
      end
    end
  end

endmodule

// ==== hw/mul_dispatch.sv ====
`include "mul_settings.svh"

module mul_dispatch (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       cyc,
  input  logic                       stb,
  input  logic                       we,
  input  logic [4:0]                 adr,
  input  mul_types_pkg::word_t       dat_w,
  input  bus_types_pkg::lane_mask_t  pending,
  input  bus_types_pkg::lane_mask_t  busy,
  input  mul_types_pkg::word_t       rd_data,
  output logic                       ack,
  output mul_types_pkg::word_t       dat_r,
  output bus_types_pkg::lane_mask_t  start,
  output mul_types_pkg::mul_op_t     op,
  output mul_types_pkg::word_t       rs1,
  output mul_types_pkg::word_t       rs2,
  output bus_types_pkg::reg_off_t    rd_sel,
  output logic                       rd_en,
  output logic                       reject
);
  import mul_types_pkg::*;
  import bus_types_pkg::*;

  logic       req;
  reg_off_t   sel;
  lane_mask_t free;
  lane_mask_t pick;
  lane_idx_t  pick_idx;
  logic       found;
  lane_idx_t  last;
  word_t      local_data;

  assign req    = cyc & stb & ~ack;  // ack is high for one cycle, so each access is taken once
  assign sel    = reg_off_t'(adr);
  assign rd_sel = sel;
  assign rd_en  = req & ~we;

  assign free = ~(busy | pending);

  always_comb begin
    pick     = '0;
    pick_idx = '0;
    found    = 1'b0;
    for (int i = 0; i < `MUL_LANES; i++) begin
      if (free[i] && !found) begin
        found    = 1'b1;
        pick[i]  = 1'b1;
        pick_idx = lane_idx_t'(i);
      end
    end
  end

  always_comb begin
    case (sel)
      OPA:     local_data = rs1;
      OPB:     local_data = rs2;
      LAST:    local_data = word_t'(last);
      default: local_data = rd_data;  // status and results come from collect
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      ack    <= 1'b0;
      dat_r  <= '0;
      start  <= '0;
      op     <= MUL_LO;
      rs1    <= '0;
      rs2    <= '0;
      last   <= '0;
      reject <= 1'b0;
    end else begin
      ack   <= req;
      start <= '0;
      if (req) begin
        dat_r <= we ? '0 : local_data;
      end
      if (req && we) begin
        case (sel)
          OPA: rs1 <= dat_w;
          OPB: rs2 <= dat_w;
          CMD: begin
            if (found) begin
              start <= pick;
              op    <= mul_op_t'(dat_w[1:0]);
              last  <= pick_idx;
            end else begin
              reject <= 1'b1;  // sticky until the next status read
            end
          end
          default: ;
        endcase
      end
      if (rd_en && sel == STATUS) begin
        reject <= 1'b0;
      end
    end
  end

endmodule

// ==== hw/mul_collect.sv ====
`include "mul_settings.svh"

module mul_collect (
  input  logic                      clk,
  input  logic                      rst,
  input  bus_types_pkg::lane_mask_t done,
  input  mul_types_pkg::word_t      result [`MUL_LANES],
  input  bus_types_pkg::lane_mask_t busy,
  input  bus_types_pkg::reg_off_t   rd_sel,
  input  logic                      rd_en,
  input  logic                      reject,
  output bus_types_pkg::lane_mask_t pending,
  output mul_types_pkg::word_t      rd_data
);
  import mul_types_pkg::*;
  import bus_types_pkg::*;

  word_t     held [`MUL_LANES];
  word_t     status;
  logic      is_result;
  lane_idx_t res_idx;

  assign is_result = (rd_sel >= RESULT0) && (rd_sel < RESULT0 + `MUL_LANES);
  assign res_idx   = lane_idx_t'(rd_sel - RESULT0);

  // pending, then busy, then reject, packed from bit 0 upward
  always_comb begin
    status = '0;
    status[`MUL_LANES-1:0] = pending;
    status[2*`MUL_LANES-1:`MUL_LANES] = busy;
    status[2*`MUL_LANES] = reject;
  end

  always_comb begin
    if (is_result) begin
      rd_data = pending[res_idx] ? held[res_idx] : '0;
    end else if (rd_sel == STATUS) begin
      rd_data = status;
    end else begin
      rd_data = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      pending <= '0;
    end else begin
      for (int i = 0; i < `MUL_LANES; i++) begin
        if (done[i]) begin
          pending[i] <= 1'b1;
        end else if (rd_en && is_result && res_idx == i) begin
          pending[i] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < `MUL_LANES; i++) begin
      if (done[i]) begin
        held[i] <= result[i];
      end
    end
  end

endmodule

// ==== hw/mul_array_top.sv ====
`include "mul_settings.svh"

module mul_array_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 cyc,
  input  logic                 stb,
  input  logic                 we,
  input  logic [4:0]           adr,
  input  mul_types_pkg::word_t dat_w,
  output logic                 ack,
  output mul_types_pkg::word_t dat_r
);
  import mul_types_pkg::*;
  import bus_types_pkg::*;

  lane_mask_t start;
  lane_mask_t busy;
  lane_mask_t done;
  lane_mask_t pending;
  mul_op_t    op;
  word_t      rs1;
  word_t      rs2;
  word_t      result [`MUL_LANES];
  reg_off_t   rd_sel;
  logic       rd_en;
  logic       reject;
  word_t      rd_data;

  mul_dispatch u_dispatch (
    .clk     (clk),
    .rst     (rst),
    .cyc     (cyc),
    .stb     (stb),
    .we      (we),
    .adr     (adr),
    .dat_w   (dat_w),
    .pending (pending),
    .busy    (busy),
    .rd_data (rd_data),
    .ack     (ack),
    .dat_r   (dat_r),
    .start   (start),
    .op      (op),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd_sel  (rd_sel),
    .rd_en   (rd_en),
    .reject  (reject)
  );

  // every lane sees the same operands, only its start bit tells it to load them
  for (genvar i = 0; i < `MUL_LANES; i++) begin : g_lane
    mul_lane u_lane (
      .clk    (clk),
      .rst    (rst),
      .start  (start[i]),
      .op     (op),
      .rs1    (rs1),
      .rs2    (rs2),
      .busy   (busy[i]),
      .done   (done[i]),
      .result (result[i])
    );
  end

  mul_collect u_collect (
    .clk     (clk),
    .rst     (rst),
    .done    (done),
    .result  (result),
    .busy    (busy),
    .rd_sel  (rd_sel),
    .rd_en   (rd_en),
    .reject  (reject),
    .pending (pending),
    .rd_data (rd_data)
  );

endmodule

// ==== tests/mul_check.sv ====
`include "mul_settings.svh"

module mul_check (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 cyc,
  input  logic                 stb,
  input  logic                 we,
  input  logic [4:0]           adr,
  input  mul_types_pkg::word_t dat_w,
  input  logic                 ack,
  input  mul_types_pkg::word_t dat_r,
  output int                   errors
);
  import mul_types_pkg::*;
  import bus_types_pkg::*;

  dword_t  ref_prod  [`MUL_LANES];
  mul_op_t ref_op    [`MUL_LANES];
  logic    ref_valid [`MUL_LANES];
  word_t   a_reg;
  word_t   b_reg;
  word_t   cmd_a;
  word_t   cmd_b;
  mul_op_t cmd_op;
  logic    cmd_open;  // a command was written and its lane is not known yet
  int      lane;
  word_t   expected;

  // the product of the extended operands fits in two words for all four operations
  function automatic dword_t full_product(input mul_op_t o, input word_t a, input word_t b);
    dword_t ea;
    dword_t eb;
    ea = {{`MUL_XLEN{a[`MUL_XLEN-1] && (o != MUL_HU)}}, a};
    eb = {{`MUL_XLEN{b[`MUL_XLEN-1] && (o == MUL_LO || o == MUL_H)}}, b};
    return ea * eb;
  endfunction

  function automatic word_t pick_word(input mul_op_t o, input dword_t p);
    return (o == MUL_LO) ? p[`MUL_XLEN-1:0] : p[2*`MUL_XLEN-1:`MUL_XLEN];
  endfunction

  always @(posedge clk) begin
    if (!rst) begin
      errors   <= 0;
      cmd_open = 1'b0;
      a_reg    = '0;
      b_reg    = '0;
      for (int i = 0; i < `MUL_LANES; i++) begin
        ref_valid[i] = 1'b0;
      end
    end else if (cyc && stb && ack) begin
      if (we) begin
        case (reg_off_t'(adr))
          OPA: a_reg = dat_w;
          OPB: b_reg = dat_w;
          CMD: begin
            cmd_a    = a_reg;
            cmd_b    = b_reg;
            cmd_op   = mul_op_t'(dat_w[1:0]);
            cmd_open = 1'b1;
          end
          default: ;
        endcase
      end else if (reg_off_t'(adr) == STATUS) begin
        if (dat_r[2*`MUL_LANES]) begin
          cmd_open = 1'b0;  // reject bit set, so the last command never reached a lane
        end
      end else if (reg_off_t'(adr) == LAST) begin
        if (cmd_open) begin
          lane            = int'(dat_r);
          ref_prod[lane]  = full_product(cmd_op, cmd_a, cmd_b);
          ref_op[lane]    = cmd_op;
          ref_valid[lane] = 1'b1;
          cmd_open        = 1'b0;
        end
      end else if (adr >= RESULT0 && adr < 5'(int'(RESULT0) + `MUL_LANES)) begin
        lane     = int'(adr) - int'(RESULT0);
        expected = ref_valid[lane] ? pick_word(ref_op[lane], ref_prod[lane]) : '0;
        if (dat_r !== expected) begin
          $display("CHECK FAILED at %0t: dat_r (lane %0d) expected %h actual %h",
                   $time, lane, expected, dat_r);
          errors <= errors + 1;
        end
        ref_valid[lane] = 1'b0;
      end
    end
  end

endmodule

// ==== tests/mul_array_tb.sv ====
`include "mul_settings.svh"

module mul_array_tb;
  import mul_types_pkg::*;
  import bus_types_pkg::*;

  localparam int RANDOM_OPS = 200;

  logic       clk;
  logic       rst;
  logic       cyc;
  logic       stb;
  logic       we;
  logic [4:0] adr;
  word_t      dat_w;
  logic       ack;
  word_t      dat_r;

  int    chk_errors;
  int    tb_errors = 0;
  int    tests_ok = 0;
  int    tests_bad = 0;
  int    mark = 0;
  int    cycles = 0;
  int    limit = 0;
  word_t full_mask;
  word_t reject_bit;
  int    vec_op [$];
  word_t vec_a [$];
  word_t vec_b [$];
  word_t vec_exp [$];

  mul_array_top DUT (
    .clk   (clk),
    .rst   (rst),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .ack   (ack),
    .dat_r (dat_r)
  );

  mul_check u_check (
    .clk    (clk),
    .rst    (rst),
    .cyc    (cyc),
    .stb    (stb),
    .we     (we),
    .adr    (adr),
    .dat_w  (dat_w),
    .ack    (ack),
    .dat_r  (dat_r),
    .errors (chk_errors)
  );

  always #10 clk = ~clk;

  // limit stays 0 until the vector file has been counted
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles >= limit) begin
      $display("run timed out after %0d cycles", cycles);
      $display("test count ok %0d bad %0d", tests_ok, tests_bad + 1);
      $display("TESTS FAILED");
      $finish;
    end
  end

  function automatic logic [4:0] result_adr(input int lane);
    return 5'(int'(RESULT0) + lane);
  endfunction

  // one classic cycle whose ack is expected on the second edge after the request is driven
  task automatic access(input logic wr, input logic [4:0] a, input word_t d, output word_t q);
    int waited;
    waited = 0;
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= wr;
    adr   <= a;
    dat_w <= d;
    do begin
      @(posedge clk);
      waited++;
    end while (!ack && waited < 8);
    if (!ack) begin
      $display("no ack at %0t for offset %0d", $time, a);
      tb_errors++;
    end else if (waited != 2) begin
      $display("ack at %0t came %0d cycles after the request, not 1", $time, waited - 1);
      tb_errors++;
    end
    q = dat_r;
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic write_reg(input logic [4:0] a, input word_t d);
    word_t unused;
    access(1'b1, a, d, unused);
  endtask

  task automatic read_reg(input logic [4:0] a, output word_t q);
    access(1'b0, a, '0, q);
  endtask

  task automatic expect_value(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
      tb_errors++;
    end
  endtask

  task automatic issue(input logic [1:0] op, input word_t a, input word_t b, output int lane);
    word_t q;
    write_reg(OPA, a);
    write_reg(OPB, b);
    write_reg(CMD, word_t'(op));
    read_reg(LAST, q);
    lane = int'(q);
  endtask

  task automatic wait_pending(input int lane);
    word_t s;
    int    polls;
    s = '0;
    polls = 0;
    while (!s[lane] && polls < 100) begin
      read_reg(STATUS, s);
      polls++;
    end
    if (!s[lane]) begin
      $display("lane %0d showed no result after %0d status reads", lane, polls);
      tb_errors++;
    end
  endtask

  // reads every pending result until no more than target commands are left open
  task automatic drain(input int target, inout int inflight);
    word_t s;
    word_t r;
    int    polls;
    polls = 0;
    do begin
      read_reg(STATUS, s);
      for (int i = 0; i < `MUL_LANES; i++) begin
        if (s[i]) begin
          read_reg(result_adr(i), r);
          inflight--;
        end
      end
      polls++;
    end while (inflight > target && polls < 100);
    if (inflight > target) begin
      $display("%0d results still missing at %0t", inflight - target, $time);
      tb_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    int total;
    @(posedge clk);  // the checker's count from the last read lands one edge later
    total = tb_errors + chk_errors;
    if (total == mark) begin
      tests_ok++;
      $display("test %s: pass", name);
    end else begin
      tests_bad++;
      $display("test %s: fail with %0d errors", name, total - mark);
    end
    mark = total;
  endtask

  initial begin
    int          fd;
    string       line;
    int          f_op;
    word_t       f_a;
    word_t       f_b;
    word_t       f_exp;
    int          lane;
    int          inflight;
    word_t       q;

    clk        = 1'b0;
    rst        = 1'b0;
    cyc        = 1'b0;
    stb        = 1'b0;
    we         = 1'b0;
    adr        = '0;
    dat_w      = '0;
    full_mask  = word_t'((1 << `MUL_LANES) - 1);
    reject_bit = word_t'(1) << (2 * `MUL_LANES);
    void'($urandom(69));

    fd = $fopen("tests/mul_input.txt", "r");
    if (fd == 0) begin
      $display("cannot open tests/mul_input.txt");
      tb_errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 0 && line[0] != "#" &&
            $sscanf(line, "%h %h %h %h", f_op, f_a, f_b, f_exp) == 4) begin
          vec_op.push_back(f_op);
          vec_a.push_back(f_a);
          vec_b.push_back(f_b);
          vec_exp.push_back(f_exp);
        end
      end
      $fclose(fd);
    end
    limit = (vec_a.size() + RANDOM_OPS + 20) * 60;

    repeat (5) @(posedge clk);
    rst <= 1'b1;

    read_reg(STATUS, q);
    expect_value("dat_r", '0, q);
    read_reg(LAST, q);
    expect_value("dat_r", '0, q);
    read_reg(RESULT0, q);
    expect_value("dat_r", '0, q);
    finish_test("state after reset");

    for (int i = 0; i < vec_a.size(); i++) begin
      issue(2'(vec_op[i]), vec_a[i], vec_b[i], lane);
      wait_pending(lane);
      read_reg(result_adr(lane), q);
      expect_value("dat_r", vec_exp[i], q);
    end
    finish_test("file vectors");

    for (int i = 0; i < `MUL_LANES; i++) begin
      issue(2'(i), 32'h8000_0003 + word_t'(i), 32'hfedc_ba98 - word_t'(i), lane);
      expect_value("dat_r", word_t'(i), word_t'(lane));
    end
    for (int i = 0; i < `MUL_LANES; i++) begin
      wait_pending(i);
    end
    for (int i = `MUL_LANES - 1; i >= 0; i--) begin
      read_reg(result_adr(i), q);
    end
    finish_test("all lanes in flight, read in reverse");

    for (int i = 0; i < `MUL_LANES; i++) begin
      issue(2'(i + 1), 32'h7fff_fff0 - word_t'(i), 32'h8000_0000 + word_t'(i), lane);
    end
    for (int i = 0; i < `MUL_LANES; i++) begin
      wait_pending(i);
    end
    write_reg(OPA, 32'h0000_0005);
    write_reg(OPB, 32'h0000_0007);
    write_reg(CMD, word_t'(MUL_LO));
    read_reg(STATUS, q);
    expect_value("dat_r", full_mask | reject_bit, q);
    read_reg(LAST, q);
    expect_value("dat_r", word_t'(`MUL_LANES - 1), q);
    read_reg(STATUS, q);
    expect_value("dat_r", full_mask, q);
    read_reg(OPA, q);
    expect_value("dat_r", 32'h0000_0005, q);
    read_reg(OPB, q);
    expect_value("dat_r", 32'h0000_0007, q);
    finish_test("command dropped with every lane holding a result");

    read_reg(result_adr(1), q);
    read_reg(STATUS, q);
    expect_value("dat_r", full_mask & ~word_t'(2), q);
    issue(MUL_HU, 32'hdead_beef, 32'h0bad_f00d, lane);
    expect_value("dat_r", word_t'(1), word_t'(lane));
    read_reg(STATUS, q);
    // the iterative lane is still shifting while the single-cycle lane already holds its result
    if (`MUL_FAST == 0) begin
      expect_value("dat_r", (full_mask & ~word_t'(2)) | (word_t'(2) << `MUL_LANES), q);
    end else begin
      expect_value("dat_r", full_mask, q);
    end
    wait_pending(1);
    for (int i = 0; i < `MUL_LANES; i++) begin
      read_reg(result_adr(i), q);
    end
    finish_test("result read frees its lane");

    inflight = 0;
    for (int n = 0; n < RANDOM_OPS; n++) begin
      if (inflight == `MUL_LANES) begin
        drain(`MUL_LANES - 1, inflight);
      end
      issue(2'($urandom()), $urandom(), $urandom(), lane);
      inflight++;
      if ($urandom() % 3 == 0) begin
        drain(inflight, inflight);  // a single pass over whatever is ready
      end
    end
    drain(0, inflight);
    finish_test("random operations");

    $display("test count ok %0d bad %0d", tests_ok, tests_bad);
    if (tests_bad == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== tests/mul_input.txt ====
# op a b expected, all hex; op 0 mul, 1 mulh, 2 mulhsu, 3 mulhu
# expected is the low word for mul and the high word for the others
0 00000000 00000000 00000000
1 00000000 00000000 00000000
2 00000000 00000000 00000000
3 00000000 00000000 00000000
0 00000007 00000006 0000002a
1 00000007 00000006 00000000
0 ffffffff ffffffff 00000001
1 ffffffff ffffffff 00000000
2 ffffffff ffffffff ffffffff
3 ffffffff ffffffff fffffffe
0 80000000 80000000 00000000
1 80000000 80000000 40000000
2 80000000 80000000 c0000000
3 80000000 80000000 40000000
0 7fffffff 7fffffff 00000001
1 7fffffff 7fffffff 3fffffff
1 7fffffff 80000000 c0000000
0 7fffffff 80000000 80000000
2 7fffffff 80000000 3fffffff
3 7fffffff 80000000 3fffffff
2 80000000 ffffffff 80000000
3 80000000 ffffffff 7fffffff
1 80000000 ffffffff 00000000
0 80000000 ffffffff 80000000
1 80000000 00000000 00000000
1 ffffffff 00000002 ffffffff
0 12345678 00000010 23456780
3 12345678 00000010 00000001
2 ffffffff 00000002 ffffffff
1 fffffffe 00000003 ffffffff

// ==== vlog.f ====
+incdir+hw
hw/mul_types_pkg.sv
hw/bus_types_pkg.sv
hw/mul_lane.sv
hw/mul_dispatch.sv
hw/mul_collect.sv
hw/mul_array_top.sv
tests/mul_check.sv
tests/mul_array_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module mul_array_tb -f vlog.f -o mul_sim \
  && ./obj_dir/mul_sim > sim.log 2>&1 \
  || { echo "build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0
